/* run_sim.sh */
#!/bin/sh
# Build and run the catch-the-block testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module top_vga_tb \
    -f top_vga.f \
    -o sim_top_vga

./obj_dir/sim_top_vga > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* sim/clk_gen.sv */
//==========================================================
// Testbench clock and power-on reset
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
    parameter int PERIOD     = 100,  // 100 ns clock period
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released away from the active edge
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* sim/scene_checker.sv */
//==========================================================
// Reference model of the game and raster, compared against
// the DUT each frame and at every displayed pixel
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module scene_checker #(
    parameter int H_ACTIVE     = 64,
    parameter int H_FP         = 4,
    parameter int H_SYNC       = 8,
    parameter int H_BP         = 4,
    parameter int V_ACTIVE     = 48,
    parameter int V_FP         = 2,
    parameter int V_SYNC       = 2,
    parameter int V_BP         = 2,
    parameter int PADDLE_W     = 16,
    parameter int PADDLE_H     = 4,
    parameter int BLOCK_W      = 8,
    parameter int PADDLE_STEP  = 4,
    parameter int BLOCK_STEP   = 6,
    parameter int BLOCK_STRIDE = 20
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         btn_left,
    input  logic                         btn_right,
    input  logic                         btn_fire,
    input  logic                         hs,
    input  logic                         vs,
    input  logic [3:0]                   r,
    input  logic [3:0]                   g,
    input  logic [3:0]                   b,
    input  game_pkg::g_state             game_state,
    input  logic [game_pkg::POS_W-1:0]   paddle_x,
    input  logic [game_pkg::POS_W-1:0]   block_x,
    input  logic [game_pkg::POS_W-1:0]   block_y,
    input  logic [game_pkg::POS_W-1:0]   score,
    output int                           tests_passed,
    output int                           tests_failed
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int VS_ROW  = V_ACTIVE + V_FP;  // Row shown when vs falls

    string            test_name = "reset";
    int               test_errs = 0;
    int               pix_prints = 0;
    game_pkg::g_state m_state = game_pkg::ST_IDLE;  // Model state
    game_pkg::cmd_t   m_cmd = game_pkg::CMD_NONE;   // Command held for this frame
    int               m_pad = (H_ACTIVE - PADDLE_W) / 2;
    int               m_bx = 0;
    int               m_by = 0;
    int               m_score = 0;
    logic             lvl_l;
    logic             lvl_r;
    logic             fire_q;
    int               fire_edges = 0;  // Rising fire edges seen on the buttons
    int               fire_used = 0;   // Edges already turned into a command
    logic             vs_q = 1'b1;
    logic             synced = 1'b0;   // Pixel position known after first vs fall
    logic             reset_checked = 1'b0;
    int               px = 0;
    int               py = 0;
    int               frame_cycles = 0;
    int               hs_low = 0;
    logic [11:0]      exp_rgb;

    initial begin
        tests_passed = 0;
        tests_failed = 0;
    end

    task automatic check_val(input string what, input int exp, input int act);
        if (exp != act) begin
            test_errs++;
            $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        pix_prints = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, test_errs);
        end
        test_errs = 0;
    endtask

    // One frame of game rules, applied where the DUT sees frame_tick
    task automatic advance_model();
        int pad_new;
        int y_new;
        if (m_state != game_pkg::ST_PLAY) begin
            m_pad = (H_ACTIVE - PADDLE_W) / 2;  // Objects parked outside of play
            m_bx  = 0;
            m_by  = 0;
            if (m_state == game_pkg::ST_IDLE) m_score = 0;
            if (m_cmd == game_pkg::CMD_FIRE) begin
                m_state = (m_state == game_pkg::ST_IDLE) ? game_pkg::ST_PLAY
                                                         : game_pkg::ST_IDLE;
            end
        end else begin
            pad_new = m_pad;
            if (m_cmd == game_pkg::CMD_LEFT) pad_new = m_pad - PADDLE_STEP;
            if (m_cmd == game_pkg::CMD_RIGHT) pad_new = m_pad + PADDLE_STEP;
            if (pad_new < 0) pad_new = 0;
            if (pad_new > H_ACTIVE - PADDLE_W) pad_new = H_ACTIVE - PADDLE_W;
            m_pad = pad_new;
            y_new = m_by + BLOCK_STEP;
            if (y_new + BLOCK_W < V_ACTIVE - PADDLE_H) begin
                m_by = y_new;  // Still falling
            end else if (!(m_bx + BLOCK_W <= pad_new || m_bx >= pad_new + PADDLE_W)) begin
                // Caught unless the block lies wholly left or right of the paddle
                m_score++;
                m_by = 0;
                m_bx = (m_bx + BLOCK_STRIDE) % (H_ACTIVE - BLOCK_W + 1);
            end else begin
                m_state = game_pkg::ST_OVER;  // Missed, block stays where it was
            end
        end
        // Command for the next frame comes from this frame's buttons
        if (fire_edges != fire_used) m_cmd = game_pkg::CMD_FIRE;
        else if (lvl_l && !lvl_r) m_cmd = game_pkg::CMD_LEFT;
        else if (lvl_r && !lvl_l) m_cmd = game_pkg::CMD_RIGHT;
        else m_cmd = game_pkg::CMD_NONE;
        fire_used = fire_edges;
    endtask

    function automatic logic [11:0] expected_rgb(input int x, input int y);
        if (x >= H_ACTIVE || y >= V_ACTIVE) return game_pkg::COL_BLANK;
        if (x >= m_bx && x < m_bx + BLOCK_W && y >= m_by && y < m_by + BLOCK_W)
            return game_pkg::COL_BLOCK;  // Block wins over the paddle
        if (y >= V_ACTIVE - PADDLE_H && x >= m_pad && x < m_pad + PADDLE_W)
            return game_pkg::COL_PADDLE;
        if (m_state == game_pkg::ST_PLAY) return game_pkg::COL_BG_PLAY;
        if (m_state == game_pkg::ST_OVER) return game_pkg::COL_BG_OVER;
        return game_pkg::COL_BG_IDLE;
    endfunction

    // Buttons are captured on the rising edge, where the testbench holds them still
    always @(posedge clk) begin
        lvl_l  <= btn_left;
        lvl_r  <= btn_right;
        fire_q <= btn_fire;
        if (btn_fire && !fire_q) fire_edges <= fire_edges + 1;
    end

    // DUT outputs are compared half a cycle after they change
    always @(negedge clk) begin
        if (rst_n) begin
            if (!reset_checked) begin
                check_val("hs after reset", 1, int'(hs));
                check_val("vs after reset", 1, int'(vs));
                check_val("state after reset", int'(game_pkg::ST_IDLE), int'(game_state));
                reset_checked = 1'b1;
            end
            if (synced) begin
                px++;
                if (px == H_TOTAL) begin
                    px = 0;
                    py = (py == V_TOTAL - 1) ? 0 : py + 1;
                end
            end
            frame_cycles++;
            if (vs_q && !vs) begin
                if (synced) check_val("frame length", H_TOTAL * V_TOTAL, frame_cycles);
                frame_cycles = 0;
                px = 0;
                py = VS_ROW;
                synced = 1'b1;
                advance_model();
                check_val("game_state", int'(m_state), int'(game_state));
                check_val("paddle_x", m_pad, int'(paddle_x));
                check_val("block_x", m_bx, int'(block_x));
                check_val("block_y", m_by, int'(block_y));
                check_val("score", m_score, int'(score));
            end
            if (!hs) begin
                hs_low++;
            end else if (hs_low != 0) begin
                check_val("hs low width", H_SYNC, hs_low);
                hs_low = 0;
            end
            if (synced) begin
                exp_rgb = expected_rgb(px, py);
                if ({r, g, b} !== exp_rgb) begin
                    test_errs++;
                    if (pix_prints < 4) begin
                        pix_prints++;
                        $display("[ERROR] %s: pixel %0d,%0d expected %h actual %h",
                                 test_name, px, py, exp_rgb, {r, g, b});
                    end
                end
            end
            vs_q = vs;
        end
    end

endmodule

`default_nettype wire

/* sim/top_vga_tb.sv */
//==========================================================
// Catch-the-block testbench applying a button table frame
// by frame on a small raster
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module top_vga_tb;

    localparam int H_ACTIVE = 64;
    localparam int H_FP     = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BP     = 4;
    localparam int V_ACTIVE = 48;
    localparam int V_FP     = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME    = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT  = 2 * FRAME;  // Cycles allowed for any wait
    localparam int N_ROWS   = 11;

    logic                       clk;
    logic                       rst_n;
    logic                       btn_left;
    logic                       btn_right;
    logic                       btn_fire;
    logic                       hs;
    logic                       vs;
    logic [3:0]                 r;
    logic [3:0]                 g;
    logic [3:0]                 b;
    game_pkg::g_state           game_state;
    logic [game_pkg::POS_W-1:0] paddle_x;
    logic [game_pkg::POS_W-1:0] block_x;
    logic [game_pkg::POS_W-1:0] block_y;
    logic [game_pkg::POS_W-1:0] score;
    int                         tests_passed;
    int                         tests_failed;

    string      row_name   [N_ROWS];
    logic [2:0] row_btn    [N_ROWS];  // {fire, right, left}
    int         row_frames [N_ROWS];

    clk_gen #(.PERIOD(100), .RST_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    top_vga #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .PADDLE_W(16), .PADDLE_H(4), .BLOCK_W(8),
        .PADDLE_STEP(4), .BLOCK_STEP(6), .BLOCK_STRIDE(20)
    ) dut (
        .clk_40(clk), .rst_n(rst_n),
        .btn_left(btn_left), .btn_right(btn_right), .btn_fire(btn_fire),
        .hs(hs), .vs(vs), .r(r), .g(g), .b(b),
        .game_state(game_state), .paddle_x(paddle_x), .block_x(block_x),
        .block_y(block_y), .score(score)
    );

    scene_checker #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
        .PADDLE_W(16), .PADDLE_H(4), .BLOCK_W(8),
        .PADDLE_STEP(4), .BLOCK_STEP(6), .BLOCK_STRIDE(20)
    ) chk (
        .clk(clk), .rst_n(rst_n),
        .btn_left(btn_left), .btn_right(btn_right), .btn_fire(btn_fire),
        .hs(hs), .vs(vs), .r(r), .g(g), .b(b),
        .game_state(game_state), .paddle_x(paddle_x), .block_x(block_x),
        .block_y(block_y), .score(score),
        .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    task automatic set_row(input int idx, input string name, input logic [2:0] btn,
                           input int frames);
        row_name[idx]   = name;
        row_btn[idx]    = btn;
        row_frames[idx] = frames;
    endtask

    // The sequence starts, steers to a catch, clamps both ways, misses, then
    // restarts and keeps the paddle still in mid screen
    task automatic load_table();
        set_row(0, "idle_after_reset", 3'b000, 2);
        set_row(1, "start_fire", 3'b100, 1);
        set_row(2, "move_left_clamp", 3'b001, 8);
        set_row(3, "both_held", 3'b011, 2);
        set_row(4, "move_right_clamp", 3'b010, 14);
        set_row(5, "neither_miss", 3'b000, 5);
        set_row(6, "over_fire", 3'b100, 1);
        set_row(7, "back_to_idle", 3'b000, 3);
        set_row(8, "fire_again", 3'b100, 1);
        set_row(9, "both_held_mid", 3'b011, 3);
        set_row(10, "play_again", 3'b000, 2);
    endtask

    task automatic drive_buttons(input logic [2:0] lvl);
        {btn_fire, btn_right, btn_left} = lvl;
    endtask

    // Returns once vs has gone low, or with ok clear after TIMEOUT cycles
    task automatic wait_vs_fall(output bit ok);
        int   cnt;
        logic prev;
        prev = vs;
        ok   = 1'b0;
        for (cnt = 0; cnt < TIMEOUT && !ok; cnt++) begin
            @(negedge clk);
            if (prev && !vs) ok = 1'b1;
            prev = vs;
        end
    endtask

    initial begin
        int  seed;
        int  i;
        int  f;
        int  d;
        bit  ok;
        bit  timed_out;
        seed      = 32'ha0c6_5a0e;
        timed_out = 1'b0;
        drive_buttons(3'b000);
        load_table();
        for (d = 0; d < 20 && !rst_n; d++) @(negedge clk);
        if (!rst_n) begin
            $display("reset was never released");
            timed_out = 1'b1;
        end
        @(posedge clk);  // Test bookkeeping runs on the rising edge, clear of the compares
        for (i = 0; i < N_ROWS && !timed_out; i++) begin
            chk.start_test(row_name[i]);
            d = 0;
            if (row_btn[i][2]) begin
                d = $random(seed) & 511;  // Fire lands somewhere in the first part of the frame
            end
            for (f = 0; f <= d; f++) @(negedge clk);
            drive_buttons(row_btn[i]);
            for (f = 0; f < row_frames[i] && !timed_out; f++) begin
                wait_vs_fall(ok);
                if (!ok) begin
                    $display("timeout: vs never fell during test %s", row_name[i]);
                    timed_out = 1'b1;
                end
            end
            @(posedge clk);  // The frame compare at the last vs fall is done by now
            chk.end_test();
        end
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (timed_out || tests_failed != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* top_vga.f */
verilog/game_pkg.sv
verilog/vga_timing.sv
verilog/input_decode.sv
verilog/state_control.sv
verilog/object_ctl.sv
verilog/draw_scene.sv
verilog/top_vga.sv
sim/clk_gen.sv
sim/scene_checker.sv
sim/top_vga_tb.sv

/* verilog/draw_scene.sv */
//==========================================================
// Pixel colour selection by priority with registered
// sync and colour outputs
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module draw_scene #(
    parameter int V_ACTIVE = 600,
    parameter int PADDLE_W = 80,
    parameter int PADDLE_H = 10,
    parameter int BLOCK_W  = 20
) (
    input  logic                         clk_40,
    input  logic                         rst_n,
    input  logic [game_pkg::POS_W-1:0]   hcount,
    input  logic [game_pkg::POS_W-1:0]   vcount,
    input  logic                         hsync,
    input  logic                         vsync,
    input  logic                         blank,
    input  game_pkg::g_state             game_state,
    input  logic [game_pkg::POS_W-1:0]   paddle_x,
    input  logic [game_pkg::POS_W-1:0]   block_x,
    input  logic [game_pkg::POS_W-1:0]   block_y,
    output logic                         hs,
    output logic                         vs,
    output logic [3:0]                   r,
    output logic [3:0]                   g,
    output logic [3:0]                   b
);

    localparam int W = game_pkg::POS_W;
    localparam logic [W-1:0] PAD_TOP = W'(V_ACTIVE - PADDLE_H);

    logic        in_block;
    logic        in_paddle;
    logic [11:0] rgb_nxt;
    logic [11:0] rgb_q;

    assign in_block  = (hcount >= block_x) && (hcount < block_x + W'(BLOCK_W)) &&
                       (vcount >= block_y) && (vcount < block_y + W'(BLOCK_W));
    // Rows below V_ACTIVE are blanked so only the top bound matters here
    assign in_paddle = (vcount >= PAD_TOP) &&
                       (hcount >= paddle_x) && (hcount < paddle_x + W'(PADDLE_W));

    always_comb begin
        if (blank) begin
            rgb_nxt = game_pkg::COL_BLANK;
        end else if (in_block) begin
            rgb_nxt = game_pkg::COL_BLOCK;  // Block is drawn over the paddle
        end else if (in_paddle) begin
            rgb_nxt = game_pkg::COL_PADDLE;
        end else begin
            case (game_state)
                game_pkg::ST_PLAY: rgb_nxt = game_pkg::COL_BG_PLAY;
                game_pkg::ST_OVER: rgb_nxt = game_pkg::COL_BG_OVER;
                default:           rgb_nxt = game_pkg::COL_BG_IDLE;
            endcase
        end
    end

    // Sync is delayed with the colour so the monitor sees them aligned
    always_ff @(posedge clk_40 or negedge rst_n) begin
        if (!rst_n) begin
            hs    <= 1'b1;
            vs    <= 1'b1;
            rgb_q <= game_pkg::COL_BLANK;
        end else begin
            hs    <= hsync;
            vs    <= vsync;
            rgb_q <= rgb_nxt;
        end
    end

    assign {r, g, b} = rgb_q;

endmodule

`default_nettype wire

/* verilog/game_pkg.sv */
//==========================================================
// Game definitions shared by the RTL blocks: coordinate
// width, game state and command enums, and the palette
//==========================================================
`default_nettype none

package game_pkg;

    // Every coordinate, counter and the score use this width
    localparam int POS_W = 12;

    // Top-level game FSM states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PLAY,
        ST_OVER
    } g_state;

    // One command is produced per frame by the decode stage
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_LEFT,
        CMD_RIGHT,
        CMD_FIRE
    } cmd_t;

    // Colours packed as {r,g,b}, 4 bits each
    localparam logic [11:0] COL_BLANK   = 12'h000;
    localparam logic [11:0] COL_BG_IDLE = 12'h444;  // Grey while waiting for a start
    localparam logic [11:0] COL_BG_PLAY = 12'h008;  // Dark blue during play
    localparam logic [11:0] COL_BG_OVER = 12'h800;  // Dark red after a miss
    localparam logic [11:0] COL_PADDLE  = 12'h0F0;
    localparam logic [11:0] COL_BLOCK   = 12'hFF0;

endpackage

`default_nettype wire

/* verilog/input_decode.sv */
//==========================================================
// Button synchronizers and per-frame command decode
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module input_decode (
    input  logic                clk_40,
    input  logic                rst_n,
    input  logic                btn_left,
    input  logic                btn_right,
    input  logic                btn_fire,
    input  logic                frame_tick,
    output game_pkg::cmd_t      cmd
);

    logic [2:0] sync_q1;       // First stage, {fire, right, left}
    logic [2:0] sync_q2;       // Second stage, safe to use
    logic       fire_prev;
    logic       fire_seen;     // Sticky until the next tick
    logic       fire_pending;

    // A rising edge on the tick cycle itself still counts for this frame
    assign fire_pending = fire_seen | (sync_q2[2] & ~fire_prev);

    always_ff @(posedge clk_40 or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1   <= '0;
            sync_q2   <= '0;
            fire_prev <= 1'b0;
            fire_seen <= 1'b0;
            cmd       <= game_pkg::CMD_NONE;
        end else begin
            sync_q1   <= {btn_fire, btn_right, btn_left};
            sync_q2   <= sync_q1;
            fire_prev <= sync_q2[2];
            if (frame_tick) begin
                fire_seen <= 1'b0;  // Start collecting for the next frame
                // Fire has priority, then a single held direction
                if (fire_pending) begin
                    cmd <= game_pkg::CMD_FIRE;
                end else if (sync_q2[0] && !sync_q2[1]) begin
                    cmd <= game_pkg::CMD_LEFT;
                end else if (sync_q2[1] && !sync_q2[0]) begin
                    cmd <= game_pkg::CMD_RIGHT;
                end else begin
                    cmd <= game_pkg::CMD_NONE;  // Both or neither held
                end
            end else begin
                fire_seen <= fire_pending;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/object_ctl.sv */
//==========================================================
// Paddle and falling block positions, catch or miss
// decision and score, all updated once per frame
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module object_ctl #(
    parameter int H_ACTIVE     = 800,
    parameter int V_ACTIVE     = 600,
    parameter int PADDLE_W     = 80,
    parameter int PADDLE_H     = 10,
    parameter int BLOCK_W      = 20,
    parameter int PADDLE_STEP  = 8,
    parameter int BLOCK_STEP   = 4,
    parameter int BLOCK_STRIDE = 150
) (
    input  logic                         clk_40,
    input  logic                         rst_n,
    input  logic                         frame_tick,
    input  game_pkg::cmd_t               cmd,
    input  game_pkg::g_state             game_state,
    output logic [game_pkg::POS_W-1:0]   paddle_x,
    output logic [game_pkg::POS_W-1:0]   block_x,
    output logic [game_pkg::POS_W-1:0]   block_y,
    output logic [game_pkg::POS_W-1:0]   score,
    output logic                         miss
);

    localparam int W = game_pkg::POS_W;
    localparam logic [W-1:0] PAD_MAX  = W'(H_ACTIVE - PADDLE_W);
    localparam logic [W-1:0] PAD_HOME = W'((H_ACTIVE - PADDLE_W) / 2);
    localparam logic [W-1:0] X_RANGE  = W'(H_ACTIVE - BLOCK_W + 1);  // Legal block_x count
    localparam logic [W-1:0] FLOOR_Y  = W'(V_ACTIVE - PADDLE_H);     // Top row of the paddle

    logic [W-1:0] pad_new;
    logic [W-1:0] y_new;
    logic [W-1:0] x_sum;
    logic         at_floor;
    logic         catch_hit;

    // Paddle step with clamping at both screen edges
    always_comb begin
        pad_new = paddle_x;
        if (cmd == game_pkg::CMD_LEFT) begin
            pad_new = (paddle_x < W'(PADDLE_STEP)) ? '0 : paddle_x - W'(PADDLE_STEP);
        end else if (cmd == game_pkg::CMD_RIGHT) begin
            pad_new = (paddle_x > PAD_MAX - W'(PADDLE_STEP)) ? PAD_MAX
                                                             : paddle_x + W'(PADDLE_STEP);
        end
    end

    assign y_new     = block_y + W'(BLOCK_STEP);
    assign at_floor  = (y_new + W'(BLOCK_W)) >= FLOOR_Y;
    // Spans overlap when each one starts before the other ends
    assign catch_hit = (block_x < pad_new + W'(PADDLE_W)) && (block_x + W'(BLOCK_W) > pad_new);
    assign x_sum     = block_x + W'(BLOCK_STRIDE);  // Wraps once at most since stride < range

    always_ff @(posedge clk_40 or negedge rst_n) begin
        if (!rst_n) begin
            paddle_x <= PAD_HOME;
            block_x  <= '0;
            block_y  <= '0;
            score    <= '0;
            miss     <= 1'b0;
        end else begin
            miss <= 1'b0;  // Single-cycle pulse
            if (frame_tick) begin
                if (game_state != game_pkg::ST_PLAY) begin
                    paddle_x <= PAD_HOME;  // Park objects outside of play
                    block_x  <= '0;
                    block_y  <= '0;
                    if (game_state == game_pkg::ST_IDLE) begin
                        score <= '0;
                    end
                end else begin
                    paddle_x <= pad_new;
                    if (!at_floor) begin
                        block_y <= y_new;
                    end else if (catch_hit) begin
                        score   <= score + 1'b1;
                        block_y <= '0;  // Drop a new block from the top
                        block_x <= (x_sum >= X_RANGE) ? x_sum - X_RANGE : x_sum;
                    end else begin
                        miss <= 1'b1;  // Block stays put, FSM moves to game over
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/state_control.sv */
//==========================================================
// Game FSM stepping through idle, play and game over
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module state_control (
    input  logic                clk_40,
    input  logic                rst_n,
    input  logic                frame_tick,
    input  game_pkg::cmd_t      cmd,
    input  logic                miss,
    output game_pkg::g_state    game_state
);

    game_pkg::g_state state_nxt;
    logic             fire_tick;

    assign fire_tick = frame_tick && (cmd == game_pkg::CMD_FIRE);  // Start or restart request

    always_comb begin
        state_nxt = game_state;
        case (game_state)
            game_pkg::ST_IDLE: begin
                if (fire_tick) begin
                    state_nxt = game_pkg::ST_PLAY;
                end
            end
            game_pkg::ST_PLAY: begin
                if (miss) begin
                    state_nxt = game_pkg::ST_OVER;  // Block reached the floor uncaught
                end
            end
            game_pkg::ST_OVER: begin
                if (fire_tick) begin
                    state_nxt = game_pkg::ST_IDLE;
                end
            end
            default: state_nxt = game_pkg::ST_IDLE;  // Recover from the unused code
        endcase
    end

    always_ff @(posedge clk_40 or negedge rst_n) begin
        if (!rst_n) begin
            game_state <= game_pkg::ST_IDLE;
        end else begin
            game_state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* verilog/top_vga.sv */
//==========================================================
// Catch-the-block game top level joining timing, input,
// game control, object control and drawing
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module top_vga #(
    parameter int H_ACTIVE     = 800,  // 800x600 at 60 Hz from a 40 MHz pixel clock
    parameter int H_FP         = 40,
    parameter int H_SYNC       = 128,
    parameter int H_BP         = 88,
    parameter int V_ACTIVE     = 600,
    parameter int V_FP         = 1,
    parameter int V_SYNC       = 4,
    parameter int V_BP         = 23,
    parameter int PADDLE_W     = 80,
    parameter int PADDLE_H     = 10,
    parameter int BLOCK_W      = 20,
    parameter int PADDLE_STEP  = 8,
    parameter int BLOCK_STEP   = 4,
    parameter int BLOCK_STRIDE = 150
) (
    input  logic                         clk_40,
    input  logic                         rst_n,
    input  logic                         btn_left,
    input  logic                         btn_right,
    input  logic                         btn_fire,
    output logic                         hs,
    output logic                         vs,
    output logic [3:0]                   r,
    output logic [3:0]                   g,
    output logic [3:0]                   b,
    output game_pkg::g_state             game_state,
    output logic [game_pkg::POS_W-1:0]   paddle_x,
    output logic [game_pkg::POS_W-1:0]   block_x,
    output logic [game_pkg::POS_W-1:0]   block_y,
    output logic [game_pkg::POS_W-1:0]   score
);

    logic [game_pkg::POS_W-1:0] hcount;
    logic [game_pkg::POS_W-1:0] vcount;
    logic                       hsync;
    logic                       vsync;
    logic                       blank;
    logic                       frame_tick;  // Start of vertical blanking
    logic                       miss;
    game_pkg::cmd_t             cmd;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_vga_timing (
        .clk_40(clk_40),
        .rst_n(rst_n),
        .hcount(hcount),
        .vcount(vcount),
        .hsync(hsync),
        .vsync(vsync),
        .blank(blank),
        .frame_tick(frame_tick)
    );

    input_decode u_input_decode (
        .clk_40(clk_40),
        .rst_n(rst_n),
        .btn_left(btn_left),
        .btn_right(btn_right),
        .btn_fire(btn_fire),
        .frame_tick(frame_tick),
        .cmd(cmd)
    );

    state_control u_state_control (
        .clk_40(clk_40),
        .rst_n(rst_n),
        .frame_tick(frame_tick),
        .cmd(cmd),
        .miss(miss),
        .game_state(game_state)
    );

    object_ctl #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
        .PADDLE_W(PADDLE_W), .PADDLE_H(PADDLE_H), .BLOCK_W(BLOCK_W),
        .PADDLE_STEP(PADDLE_STEP), .BLOCK_STEP(BLOCK_STEP), .BLOCK_STRIDE(BLOCK_STRIDE)
    ) u_object_ctl (
        .clk_40(clk_40),
        .rst_n(rst_n),
        .frame_tick(frame_tick),
        .cmd(cmd),
        .game_state(game_state),
        .paddle_x(paddle_x),
        .block_x(block_x),
        .block_y(block_y),
        .score(score),
        .miss(miss)
    );

    draw_scene #(
        .V_ACTIVE(V_ACTIVE), .PADDLE_W(PADDLE_W), .PADDLE_H(PADDLE_H), .BLOCK_W(BLOCK_W)
    ) u_draw_scene (
        .clk_40(clk_40),
        .rst_n(rst_n),
        .hcount(hcount),
        .vcount(vcount),
        .hsync(hsync),
        .vsync(vsync),
        .blank(blank),
        .game_state(game_state),
        .paddle_x(paddle_x),
        .block_x(block_x),
        .block_y(block_y),
        .hs(hs),
        .vs(vs),
        .r(r),
        .g(g),
        .b(b)
    );

endmodule

`default_nettype wire

/* verilog/vga_timing.sv */
//==========================================================
// VGA raster generator with counters, sync, blanking and a
// one-cycle tick at the start of vertical blanking
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FP     = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BP     = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BP     = 23
) (
    input  logic                         clk_40,
    input  logic                         rst_n,
    output logic [game_pkg::POS_W-1:0]   hcount,
    output logic [game_pkg::POS_W-1:0]   vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         blank,
    output logic                         frame_tick
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HS_BEG  = H_ACTIVE + H_FP;  // First count with hsync low
    localparam int VS_BEG  = V_ACTIVE + V_FP;

    logic [game_pkg::POS_W-1:0] h_next;
    logic [game_pkg::POS_W-1:0] v_next;
    logic                       line_end;

    // Decode is done on the next count so that the registered sync and
    // blank line up with the counter outputs in the same cycle
    assign line_end = (hcount == game_pkg::POS_W'(H_TOTAL - 1));
    assign h_next   = line_end ? '0 : hcount + 1'b1;

    always_comb begin
        v_next = vcount;
        if (line_end) begin
            v_next = (vcount == game_pkg::POS_W'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
        end
    end

    always_ff @(posedge clk_40 or negedge rst_n) begin
        if (!rst_n) begin
            hcount     <= '0;
            vcount     <= '0;
            hsync      <= 1'b1;  // Sync is idle high out of reset
            vsync      <= 1'b1;
            blank      <= 1'b0;  // Pixel 0,0 is active
            frame_tick <= 1'b0;
        end else begin
            hcount     <= h_next;
            vcount     <= v_next;
            hsync      <= !((h_next >= HS_BEG) && (h_next < HS_BEG + H_SYNC));
            vsync      <= !((v_next >= VS_BEG) && (v_next < VS_BEG + V_SYNC));
            blank      <= (h_next >= H_ACTIVE) || (v_next >= V_ACTIVE);
            frame_tick <= (h_next == '0) && (v_next == game_pkg::POS_W'(V_ACTIVE));
        end
    end

endmodule

`default_nettype wire
